/* hdl/lsu_pkg.sv */
package lsu_pkg;

    // data and address width
    localparam int XLEN = 32;
    // byte enables per word
    localparam int MASK_W = 4;
    // op code widths
    localparam int MEMOP_W = 4;
    localparam int AMOOP_W = 4;
    // size field on the memory bus
    localparam int MEM_SIZE_W = 4;
    // low address bits that select the byte lane
    localparam int OFF_W = 2;

    // bit positions inside the one-hot size
    localparam int SZ_B = 0;
    localparam int SZ_H = 1;
    localparam int SZ_W = 2;

    // SC.W return codes
    localparam logic [XLEN-1:0] SC_OK_CODE = 32'd0;
    localparam logic [XLEN-1:0] SC_FAIL_CODE = 32'd1;

    // memory op from execute
    typedef enum logic [MEMOP_W-1:0] {
        MEMOP_NONE,
        MEMOP_LB,
        MEMOP_LBU,
        MEMOP_LH,
        MEMOP_LHU,
        MEMOP_LW,
        MEMOP_SB,
        MEMOP_SH,
        MEMOP_SW,
        MEMOP_LR_W,
        MEMOP_SC_W,
        MEMOP_AMO
    } memop_e;

    // AMO sub-op, only meaningful with MEMOP_AMO
    typedef enum logic [AMOOP_W-1:0] {
        AMOOP_SWAP,
        AMOOP_ADD,
        AMOOP_XOR,
        AMOOP_AND,
        AMOOP_OR,
        AMOOP_MIN,
        AMOOP_MAX,
        AMOOP_MINU,
        AMOOP_MAXU
    } amoop_e;

    // signed view of a data word, for AMOMIN / AMOMAX
    typedef logic signed [XLEN-1:0] sword_t;

    // instruction arriving from execute, addr is also the ALU result
    typedef struct packed {
        memop_e           op;
        amoop_e           amo_op;
        logic [XLEN-1:0]  addr;
        logic [XLEN-1:0]  rs2;
    } lsu_req_t;

    // decoded op class
    typedef struct packed {
        logic       is_load;
        logic       is_store;
        logic       is_lr;
        logic       is_sc;
        logic       is_amo;
        logic       is_signed;
        logic [2:0] size;
    } op_class_t;

    // data memory request
    typedef struct packed {
        logic [XLEN-1:0]       addr;
        logic                  valid;
        logic                  write;
        logic [MASK_W-1:0]     mask;
        logic [MEM_SIZE_W-1:0] size;
        logic [XLEN-1:0]       wdata;
    } mem_req_t;

    // memory phase asked for by the atomic sequencer
    typedef struct packed {
        logic rd;
        logic wr;
    } amo_phase_t;

endpackage

/* hdl/lsu_req_decode.sv */
`timescale 1ns/1ps

module lsu_req_decode
    import lsu_pkg::*;
(
    input  lsu_req_t         req_i,
    input  amo_phase_t       phase_i,
    input  logic [XLEN-1:0]  amo_wdata_i,
    input  logic             mem_ready_i,
    output op_class_t        class_o,
    output mem_req_t         mem_req_o,
    output logic             misalign_o
);

    op_class_t         cls;
    logic              is_atomic;
    logic              wr_type;
    logic              plain_valid;
    logic [OFF_W-1:0]  off;
    logic [MASK_W-1:0] base_mask;

    // op decode into class and one-hot size
    always_comb begin
        cls = '0;
        case (req_i.op)
            MEMOP_LB: begin
                cls.is_load = 1'b1;
                cls.is_signed = 1'b1;
                cls.size[SZ_B] = 1'b1;
            end
            MEMOP_LBU: begin
                cls.is_load = 1'b1;
                cls.size[SZ_B] = 1'b1;
            end
            MEMOP_LH: begin
                cls.is_load = 1'b1;
                cls.is_signed = 1'b1;
                cls.size[SZ_H] = 1'b1;
            end
            MEMOP_LHU: begin
                cls.is_load = 1'b1;
                cls.size[SZ_H] = 1'b1;
            end
            MEMOP_LW: begin
                cls.is_load = 1'b1;
                cls.size[SZ_W] = 1'b1;
            end
            MEMOP_SB: begin
                cls.is_store = 1'b1;
                cls.size[SZ_B] = 1'b1;
            end
            MEMOP_SH: begin
                cls.is_store = 1'b1;
                cls.size[SZ_H] = 1'b1;
            end
            MEMOP_SW: begin
                cls.is_store = 1'b1;
                cls.size[SZ_W] = 1'b1;
            end
            // atomics always move a full word
            MEMOP_LR_W: begin
                cls.is_lr = 1'b1;
                cls.size[SZ_W] = 1'b1;
            end
            MEMOP_SC_W: begin
                cls.is_sc = 1'b1;
                cls.size[SZ_W] = 1'b1;
            end
            MEMOP_AMO: begin
                cls.is_amo = 1'b1;
                cls.size[SZ_W] = 1'b1;
            end
            default: cls = '0;
        endcase
    end

    assign is_atomic = cls.is_lr | cls.is_sc | cls.is_amo;
    assign off = req_i.addr[OFF_W-1:0];

    // unshifted mask from size
    always_comb begin
        base_mask = '0;
        if (cls.size[SZ_B]) begin
            base_mask = MASK_W'(4'b0001);
        end else if (cls.size[SZ_H]) begin
            base_mask = MASK_W'(4'b0011);
        end else if (cls.size[SZ_W]) begin
            base_mask = {MASK_W{1'b1}};
        end
    end

    // plain access drops valid once memory answers
    assign plain_valid = (cls.is_load | cls.is_store) & ~mem_ready_i;
    // write-type access, mask gets lane shift
    assign wr_type = cls.is_store | (is_atomic & phase_i.wr);

    always_comb begin
        mem_req_o.addr = req_i.addr;
        mem_req_o.size = {1'b0, cls.size};
        mem_req_o.mask = wr_type ? (base_mask << off) : base_mask;
        if (is_atomic) begin
            // sequencer owns the phases and the store word
            mem_req_o.valid = phase_i.rd | phase_i.wr;
            mem_req_o.write = phase_i.wr;
            mem_req_o.wdata = amo_wdata_i;
        end else begin
            mem_req_o.valid = plain_valid;
            mem_req_o.write = cls.is_store & plain_valid;
            // move store data into its byte lane
            mem_req_o.wdata = req_i.rs2 << {off, 3'b000};
        end
    end

    assign class_o = cls;
    // atomics must be word aligned
    assign misalign_o = is_atomic & (off != '0);

endmodule

/* hdl/amo_alu.sv */
`timescale 1ns/1ps

module amo_alu
    import lsu_pkg::*;
(
    input  amoop_e           amo_op_i,
    input  logic [XLEN-1:0]  old_i,
    input  logic [XLEN-1:0]  rs2_i,
    output logic [XLEN-1:0]  new_o
);

    logic s_lt;
    logic u_lt;

    // signed and unsigned compare of old word against rs2
    assign s_lt = sword_t'(old_i) < sword_t'(rs2_i);
    assign u_lt = old_i < rs2_i;

    always_comb begin
        case (amo_op_i)
            AMOOP_SWAP: new_o = rs2_i;
            AMOOP_ADD:  new_o = old_i + rs2_i;
            AMOOP_XOR:  new_o = old_i ^ rs2_i;
            AMOOP_AND:  new_o = old_i & rs2_i;
            AMOOP_OR:   new_o = old_i | rs2_i;
            // min keeps the smaller, ties give rs2 which is equal anyway
            AMOOP_MIN:  new_o = s_lt ? old_i : rs2_i;
            AMOOP_MAX:  new_o = s_lt ? rs2_i : old_i;
            AMOOP_MINU: new_o = u_lt ? old_i : rs2_i;
            AMOOP_MAXU: new_o = u_lt ? rs2_i : old_i;
            // unknown op falls back to swap
            default:    new_o = rs2_i;
        endcase
    end

endmodule

/* hdl/amo_sequencer.sv */
`timescale 1ns/1ps

module amo_sequencer
    import lsu_pkg::*;
(
    input  logic             clk,
    input  logic             rst,
    input  op_class_t        class_i,
    input  lsu_req_t         req_i,
    input  logic             amo_valid_i,
    input  logic             mem_ready_i,
    input  logic [XLEN-1:0]  mem_rdata_i,
    output amo_phase_t       phase_o,
    output logic [XLEN-1:0]  wdata_o,
    output logic [XLEN-1:0]  result_o,
    output logic             done_o,
    output logic             busy_o
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_LOAD,
        S_CALC,
        S_STORE
    } state_e;

    state_e           state_q;
    logic             valid_q;
    logic             start;
    logic             done_q;
    logic             resv_valid_q;
    logic [XLEN-1:0]  resv_addr_q;
    logic [XLEN-1:0]  loaded_q;
    logic [XLEN-1:0]  calc_q;
    logic [XLEN-1:0]  result_q;
    logic [XLEN-1:0]  alu_new;
    logic             sc_hit;

    // new word from loaded value and rs2
    amo_alu i_amo_alu (
        .amo_op_i (req_i.amo_op),
        .old_i    (loaded_q),
        .rs2_i    (req_i.rs2),
        .new_o    (alu_new)
    );

    // rising edge of valid starts an atomic
    assign start = amo_valid_i & ~valid_q;
    // SC succeeds only on a live reservation to the same address
    assign sc_hit = resv_valid_q & (resv_addr_q == req_i.addr);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q <= S_IDLE;
            valid_q <= 1'b0;
            done_q <= 1'b0;
            resv_valid_q <= 1'b0;
            result_q <= '0;
        end else begin
            valid_q <= amo_valid_i;
            // done is a single-cycle pulse
            done_q <= 1'b0;
            case (state_q)
                S_IDLE: begin
                    if (start && class_i.is_lr) begin
                        resv_valid_q <= 1'b1;
                        state_q <= S_LOAD;
                    end else if (start && class_i.is_sc) begin
                        if (sc_hit) begin
                            state_q <= S_STORE;
                        end else begin
                            // failed SC skips memory entirely
                            result_q <= SC_FAIL_CODE;
                            resv_valid_q <= 1'b0;
                            done_q <= 1'b1;
                        end
                    end else if (start && class_i.is_amo) begin
                        state_q <= S_LOAD;
                    end
                end
                S_LOAD: begin
                    if (mem_ready_i) begin
                        if (class_i.is_amo) begin
                            state_q <= S_CALC;
                        end else begin
                            // LR.W returns the loaded word
                            result_q <= mem_rdata_i;
                            done_q <= 1'b1;
                            state_q <= S_IDLE;
                        end
                    end
                end
                // one cycle for the ALU
                S_CALC: state_q <= S_STORE;
                S_STORE: begin
                    if (mem_ready_i) begin
                        if (class_i.is_sc) begin
                            result_q <= SC_OK_CODE;
                            resv_valid_q <= 1'b0;
                        end else begin
                            // AMO hands back the old word
                            result_q <= loaded_q;
                        end
                        done_q <= 1'b1;
                        state_q <= S_IDLE;
                    end
                end
                default: state_q <= S_IDLE;
            endcase
            // any plain store kills the reservation
            if (class_i.is_store) begin
                resv_valid_q <= 1'b0;
            end
        end
    end

    // data registers
    always_ff @(posedge clk) begin
        if (state_q == S_IDLE && start && class_i.is_lr) begin
            resv_addr_q <= req_i.addr;
        end
        if (state_q == S_LOAD && mem_ready_i) begin
            loaded_q <= mem_rdata_i;
        end
        if (state_q == S_CALC) begin
            calc_q <= alu_new;
        end
    end

    assign phase_o.rd = (state_q == S_LOAD);
    assign phase_o.wr = (state_q == S_STORE);
    // SC writes rs2 as is, AMO writes the ALU word
    assign wdata_o = class_i.is_sc ? req_i.rs2 : calc_q;
    assign result_o = result_q;
    assign done_o = done_q;
    assign busy_o = (state_q != S_IDLE) & ~done_q;

endmodule

/* hdl/lsu_wb_format.sv */
`timescale 1ns/1ps

module lsu_wb_format
    import lsu_pkg::*;
(
    input  op_class_t        class_i,
    input  lsu_req_t         req_i,
    input  logic [XLEN-1:0]  mem_rdata_i,
    input  logic [XLEN-1:0]  amo_result_i,
    output logic [XLEN-1:0]  wb_data_o
);

    logic [7:0]       rd_byte;
    logic [15:0]      rd_half;
    logic [XLEN-1:0]  load_ext;
    logic             is_atomic;

    // read data taken at lane zero, no shift on the read side
    assign rd_byte = mem_rdata_i[7:0];
    assign rd_half = mem_rdata_i[15:0];

    // sign or zero extension by size
    always_comb begin
        if (class_i.size[SZ_B]) begin
            load_ext = {{(XLEN-8){class_i.is_signed & rd_byte[7]}}, rd_byte};
        end else if (class_i.size[SZ_H]) begin
            load_ext = {{(XLEN-16){class_i.is_signed & rd_half[15]}}, rd_half};
        end else begin
            load_ext = mem_rdata_i;
        end
    end

    assign is_atomic = class_i.is_lr | class_i.is_sc | class_i.is_amo;

    // atomic result first, then load data, else the ALU result
    always_comb begin
        if (is_atomic) begin
            wb_data_o = amo_result_i;
        end else if (class_i.is_load) begin
            wb_data_o = load_ext;
        end else begin
            wb_data_o = req_i.addr;
        end
    end

endmodule

/* hdl/lsu_top.sv */
`timescale 1ns/1ps

module lsu_top
    import lsu_pkg::*;
(
    input  logic             clk,
    input  logic             rst,
    input  lsu_req_t         req_i,
    input  logic             amo_valid_i,
    input  logic             mem_ready_i,
    input  logic [XLEN-1:0]  mem_rdata_i,
    output mem_req_t         mem_req_o,
    output logic [XLEN-1:0]  wb_data_o,
    output logic [XLEN-1:0]  amo_result_o,
    output logic             amo_done_o,
    output logic             amo_misalign_o,
    output logic             stall_o
);

    op_class_t        op_class;
    amo_phase_t       amo_phase;
    logic [XLEN-1:0]  amo_wdata;
    logic [XLEN-1:0]  amo_result;
    logic             amo_busy;
    mem_req_t         mem_req;

    // request decode, drives the memory bus
    lsu_req_decode i_req_decode (
        .req_i       (req_i),
        .phase_i     (amo_phase),
        .amo_wdata_i (amo_wdata),
        .mem_ready_i (mem_ready_i),
        .class_o     (op_class),
        .mem_req_o   (mem_req),
        .misalign_o  (amo_misalign_o)
    );

    // LR / SC / AMO sequencing and reservation
    amo_sequencer i_amo_sequencer (
        .clk         (clk),
        .rst         (rst),
        .class_i     (op_class),
        .req_i       (req_i),
        .amo_valid_i (amo_valid_i),
        .mem_ready_i (mem_ready_i),
        .mem_rdata_i (mem_rdata_i),
        .phase_o     (amo_phase),
        .wdata_o     (amo_wdata),
        .result_o    (amo_result),
        .done_o      (amo_done_o),
        .busy_o      (amo_busy)
    );

    // write-back value select
    lsu_wb_format i_wb_format (
        .class_i      (op_class),
        .req_i        (req_i),
        .mem_rdata_i  (mem_rdata_i),
        .amo_result_i (amo_result),
        .wb_data_o    (wb_data_o)
    );

    assign mem_req_o = mem_req;
    assign amo_result_o = amo_result;
    // hold the pipe while memory or the sequencer is busy
    assign stall_o = mem_req.valid | amo_busy;

endmodule

/* dv/lsu_top_props.sv */
`timescale 1ns/1ps

module lsu_top_props
    import lsu_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  lsu_req_t  req_i,
    input  logic      mem_ready_i,
    input  mem_req_t  mem_req_o,
    input  logic      amo_done_o,
    input  logic      amo_misalign_o,
    input  logic      stall_o
);

    // read by the testbench monitor
    int unsigned fail_count = 0;
    logic        is_plain;
    logic        is_store;
    logic        is_atomic;
    logic [1:0]  off;

    assign is_plain = req_i.op inside {[MEMOP_LB:MEMOP_SW]};
    assign is_store = req_i.op inside {MEMOP_SB, MEMOP_SH, MEMOP_SW};
    assign is_atomic = req_i.op inside {MEMOP_LR_W, MEMOP_SC_W, MEMOP_AMO};
    assign off = req_i.addr[1:0];

    // size mask moved up by the byte offset
    function automatic logic [MASK_W-1:0] lane_mask(memop_e op, logic [1:0] o);
        logic [MASK_W-1:0] m;
        case (op)
            MEMOP_SB: m = 4'b0001;
            MEMOP_SH: m = 4'b0011;
            default:  m = 4'b1111;
        endcase
        return m << o;
    endfunction

    // access width in bytes as carried on the bus size field
    function automatic logic [3:0] size_bytes(memop_e op);
        case (op)
            MEMOP_LB, MEMOP_LBU, MEMOP_SB: return 4'd1;
            MEMOP_LH, MEMOP_LHU, MEMOP_SH: return 4'd2;
            default:                       return 4'd4;
        endcase
    endfunction

    // waiting plain access keeps valid and stall up
    a_plain_wait: assert property (@(posedge clk) disable iff (rst)
        is_plain && !mem_ready_i |-> mem_req_o.valid && stall_o)
    else begin
        fail_count++;
        $error("plain request not held while memory is not ready");
    end

    // valid drops in the ready cycle, so stall drops too
    a_plain_ack: assert property (@(posedge clk) disable iff (rst)
        is_plain && mem_ready_i |-> !mem_req_o.valid && !stall_o)
    else begin
        fail_count++;
        $error("plain request still valid while memory is ready");
    end

    a_store_lane: assert property (@(posedge clk) disable iff (rst)
        is_store && !mem_ready_i |-> mem_req_o.write
            && mem_req_o.mask == lane_mask(req_i.op, off)
            && mem_req_o.wdata == (req_i.rs2 << (8 * off)))
    else begin
        fail_count++;
        $error("store mask or lane data wrong, mask %h wdata %h",
            mem_req_o.mask, mem_req_o.wdata);
    end

    // bus size follows the access width
    a_req_size: assert property (@(posedge clk) disable iff (rst)
        mem_req_o.valid |-> mem_req_o.size == size_bytes(req_i.op))
    else begin
        fail_count++;
        $error("memory request size %h wrong for the op", mem_req_o.size);
    end

    // no op means no memory traffic
    a_idle_quiet: assert property (@(posedge clk) disable iff (rst)
        req_i.op == MEMOP_NONE |-> !mem_req_o.valid)
    else begin
        fail_count++;
        $error("memory request valid with no op");
    end

    a_misalign: assert property (@(posedge clk) disable iff (rst)
        amo_misalign_o == (is_atomic && off != 2'b00))
    else begin
        fail_count++;
        $error("misaligned atomic flag wrong for addr %h", req_i.addr);
    end

    // done lasts one cycle and stall is released with it
    a_done_pulse: assert property (@(posedge clk) disable iff (rst)
        amo_done_o |-> !stall_o ##1 !amo_done_o)
    else begin
        fail_count++;
        $error("atomic done longer than one cycle or stall still high");
    end

    // atomic phase waiting on memory holds the pipe
    a_amo_stall: assert property (@(posedge clk) disable iff (rst)
        is_atomic && mem_req_o.valid && !mem_ready_i |-> stall_o)
    else begin
        fail_count++;
        $error("stall low while an atomic phase waits for memory");
    end

    // atomic phase request frozen under back-pressure
    a_amo_hold: assert property (@(posedge clk) disable iff (rst)
        is_atomic && mem_req_o.valid && !mem_ready_i |=> $stable(mem_req_o))
    else begin
        fail_count++;
        $error("atomic memory request changed while memory not ready");
    end

endmodule

bind lsu_top lsu_top_props i_props (
    .clk            (clk),
    .rst            (rst),
    .req_i          (req_i),
    .mem_ready_i    (mem_ready_i),
    .mem_req_o      (mem_req_o),
    .amo_done_o     (amo_done_o),
    .amo_misalign_o (amo_misalign_o),
    .stall_o        (stall_o)
);

/* dv/tb_lsu_top.sv */
`timescale 1ns/1ps

module tb_lsu_top
    import lsu_pkg::*;
();

    localparam int CLK_PERIOD = 20;
    localparam int RST_CYCLES = 10;
    localparam int N_PLAIN = 48;
    localparam int MEM_WORDS = 16;
    // plain ops, two phases per AMO, LR/SC sequence, misaligned probes
    localparam int TXN_COUNT = N_PLAIN + 2 * 9 + 9 + 2;
    // x^32 + x^22 + x^2 + x + 1
    localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

    logic            clk;
    logic            rst;
    lsu_req_t        req;
    logic            amo_valid;
    logic            mem_ready;
    logic [XLEN-1:0] mem_rdata;
    mem_req_t        mem_req;
    logic [XLEN-1:0] wb_data;
    logic [XLEN-1:0] amo_result;
    logic            amo_done;
    logic            amo_misalign;
    logic            stall;

    logic [31:0]     lfsr_q;
    // bus-written memory and its expected image
    logic [XLEN-1:0] mem [MEM_WORDS];
    logic [XLEN-1:0] ref_mem [MEM_WORDS];
    logic            resv_valid;
    logic [XLEN-1:0] resv_addr;

    lsu_top i_dut (
        .clk            (clk),
        .rst            (rst),
        .req_i          (req),
        .amo_valid_i    (amo_valid),
        .mem_ready_i    (mem_ready),
        .mem_rdata_i    (mem_rdata),
        .mem_req_o      (mem_req),
        .wb_data_o      (wb_data),
        .amo_result_o   (amo_result),
        .amo_done_o     (amo_done),
        .amo_misalign_o (amo_misalign),
        .stall_o        (stall)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic stop_with_failure(string why);
        $display("%s", why);
        $display("SIMULATION FAILED");
        $fatal(1, "run stopped on error");
    endtask

    initial begin
        #((TXN_COUNT * 8 + RST_CYCLES) * CLK_PERIOD);
        stop_with_failure("watchdog expired before the test sequence finished");
    end

    // bound properties count their failures
    always @(negedge clk) begin
        if (i_dut.i_props.fail_count != 0) begin
            stop_with_failure("a bound protocol assertion failed");
        end
    end

    // one LFSR step per bit taken
    function automatic logic [31:0] lfsr_bits(int n);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            val = {val[30:0], lfsr_q[0]};
            lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ LFSR_TAPS) : (lfsr_q >> 1);
        end
        return val;
    endfunction

    function automatic logic [XLEN-1:0] amo_model(amoop_e op, logic [XLEN-1:0] a,
                                                  logic [XLEN-1:0] b);
        case (op)
            AMOOP_SWAP: return b;
            AMOOP_ADD:  return a + b;
            AMOOP_XOR:  return a ^ b;
            AMOOP_AND:  return a & b;
            AMOOP_OR:   return a | b;
            AMOOP_MIN:  return ($signed(a) < $signed(b)) ? a : b;
            AMOOP_MAX:  return ($signed(a) > $signed(b)) ? a : b;
            AMOOP_MINU: return (a < b) ? a : b;
            default:    return (a > b) ? a : b;
        endcase
    endfunction

    // load value from lane zero of the read word
    function automatic logic [XLEN-1:0] load_model(memop_e op, logic [XLEN-1:0] w);
        case (op)
            MEMOP_LB:  return {{24{w[7]}}, w[7:0]};
            MEMOP_LBU: return {24'h0, w[7:0]};
            MEMOP_LH:  return {{16{w[15]}}, w[15:0]};
            MEMOP_LHU: return {16'h0, w[15:0]};
            default:   return w;
        endcase
    endfunction

    task automatic check_value(string name, logic [XLEN-1:0] got, logic [XLEN-1:0] exp);
        assert (got === exp) else begin
            $display("FAIL %s got %h expected %h", name, got, exp);
            stop_with_failure("value mismatch");
        end
    endtask

    // byte enables pick which lanes land in the model
    task automatic apply_write(mem_req_t r);
        int w;
        w = int'(r.addr[5:2]);
        for (int b = 0; b < MASK_W; b++) begin
            if (r.mask[b]) begin
                mem[w][8*b +: 8] = r.wdata[8*b +: 8];
            end
        end
    endtask

    // entered at a negedge with valid up and answers after 0..3 cycles
    task automatic serve_request(output logic [XLEN-1:0] wb_seen);
        mem_req_t r;
        repeat (lfsr_bits(2)) @(negedge clk);
        r = mem_req;
        if (r.write) begin
            apply_write(r);
        end
        @(posedge clk);
        #2;
        mem_rdata = mem[r.addr[5:2]];
        mem_ready = 1'b1;
        @(negedge clk);
        wb_seen = wb_data;
        @(posedge clk);
        #2;
        mem_ready = 1'b0;
    endtask

    task automatic drive_request(memop_e op, amoop_e aop, logic [XLEN-1:0] addr,
                                 logic [XLEN-1:0] rs2);
        @(posedge clk);
        #2;
        req.op = op;
        req.amo_op = aop;
        req.addr = addr;
        req.rs2 = rs2;
    endtask

    task automatic plain_access(memop_e op, logic [XLEN-1:0] addr, logic [XLEN-1:0] rs2);
        int              w;
        int              nb;
        logic [1:0]      off;
        logic [XLEN-1:0] wb_seen;
        w = int'(addr[5:2]);
        off = addr[1:0];
        drive_request(op, AMOOP_SWAP, addr, rs2);
        @(negedge clk);
        serve_request(wb_seen);
        req.op = MEMOP_NONE;
        if (op inside {MEMOP_SB, MEMOP_SH, MEMOP_SW}) begin
            nb = (op == MEMOP_SB) ? 1 : ((op == MEMOP_SH) ? 2 : 4);
            // rs2 bytes go up from the offset and lanes past the word drop out
            for (int k = 0; k < nb; k++) begin
                if (off + k < 4) begin
                    ref_mem[w][8*(off+k) +: 8] = rs2[8*k +: 8];
                end
            end
            resv_valid = 1'b0;
            check_value($sformatf("mem[%0d]", w), mem[w], ref_mem[w]);
        end else begin
            check_value("wb_data_o", wb_seen, load_model(op, ref_mem[w]));
        end
    endtask

    task automatic atomic_access(memop_e op, amoop_e aop, logic [XLEN-1:0] addr,
                                 logic [XLEN-1:0] rs2);
        int              w;
        logic [XLEN-1:0] old;
        logic [XLEN-1:0] exp_res;
        logic [XLEN-1:0] wb_seen;
        logic            finished;
        w = int'(addr[5:2]);
        old = ref_mem[w];
        drive_request(op, aop, addr, rs2);
        amo_valid = 1'b1;
        finished = 1'b0;
        // serve read and write phases until done
        while (!finished) begin
            @(negedge clk);
            if (amo_done) begin
                finished = 1'b1;
            end else if (mem_req.valid) begin
                serve_request(wb_seen);
            end
        end
        case (op)
            MEMOP_LR_W: begin
                exp_res = old;
                resv_valid = 1'b1;
                resv_addr = addr;
            end
            MEMOP_SC_W: begin
                if (resv_valid && resv_addr == addr) begin
                    exp_res = SC_OK_CODE;
                    ref_mem[w] = rs2;
                end else begin
                    exp_res = SC_FAIL_CODE;
                end
                resv_valid = 1'b0;
            end
            default: begin
                exp_res = old;
                ref_mem[w] = amo_model(aop, old, rs2);
            end
        endcase
        check_value("amo_result_o", amo_result, exp_res);
        check_value($sformatf("mem[%0d]", w), mem[w], ref_mem[w]);
        @(posedge clk);
        #2;
        amo_valid = 1'b0;
        req.op = MEMOP_NONE;
    endtask

    // atomic op shown without valid so only the flag matters
    task automatic probe_misalign(memop_e op, logic [XLEN-1:0] addr);
        drive_request(op, AMOOP_ADD, addr, '0);
        @(negedge clk);
        check_value("amo_misalign_o", XLEN'(amo_misalign), XLEN'(addr[1:0] != 2'b00));
        @(posedge clk);
        #2;
        req.op = MEMOP_NONE;
    endtask

    initial begin
        logic [XLEN-1:0] a;
        memop_e          op;
        lfsr_q = 32'd30;
        rst = 1'b1;
        req = '0;
        amo_valid = 1'b0;
        mem_ready = 1'b0;
        mem_rdata = '0;
        resv_valid = 1'b0;
        resv_addr = '0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = 32'h8bad_f00d ^ (32'(i) * 32'h0101_0101) ^ (32'(i) << 28);
            ref_mem[i] = mem[i];
        end
        repeat (RST_CYCLES) @(posedge clk);
        #2;
        rst = 1'b0;
        // random loads and stores from LB to SW
        for (int i = 0; i < N_PLAIN; i++) begin
            op = memop_e'(int'(MEMOP_LB) + int'(lfsr_bits(3)));
            plain_access(op, XLEN'(lfsr_bits(6)), lfsr_bits(32));
        end
        for (int k = 0; k < 9; k++) begin
            atomic_access(MEMOP_AMO, amoop_e'(k), XLEN'(lfsr_bits(4)) << 2, lfsr_bits(32));
        end
        a = XLEN'(lfsr_bits(4)) << 2;
        // matching pair succeeds
        atomic_access(MEMOP_LR_W, AMOOP_SWAP, a, '0);
        atomic_access(MEMOP_SC_W, AMOOP_SWAP, a, lfsr_bits(32));
        // other address fails
        atomic_access(MEMOP_LR_W, AMOOP_SWAP, a, '0);
        atomic_access(MEMOP_SC_W, AMOOP_SWAP, a ^ 32'h4, lfsr_bits(32));
        // store in between kills the reservation
        atomic_access(MEMOP_LR_W, AMOOP_SWAP, a, '0);
        plain_access(MEMOP_SW, a, lfsr_bits(32));
        atomic_access(MEMOP_SC_W, AMOOP_SWAP, a, lfsr_bits(32));
        atomic_access(MEMOP_SC_W, AMOOP_SWAP, a, lfsr_bits(32));
        probe_misalign(MEMOP_AMO, 32'h0000_0011);
        probe_misalign(MEMOP_LR_W, 32'h0000_0006);
        repeat (2) @(posedge clk);
        #2;
        if (i_dut.i_props.fail_count != 0) begin
            stop_with_failure("a bound protocol assertion failed");
        end else begin
            $display("SIMULATION PASSED");
            $finish;
        end
    end

endmodule

/* lsu_top.f */
hdl/lsu_pkg.sv
hdl/lsu_req_decode.sv
hdl/amo_alu.sv
hdl/amo_sequencer.sv
hdl/lsu_wb_format.sv
hdl/lsu_top.sv
dv/lsu_top_props.sv
dv/tb_lsu_top.sv
